//--- build.f
+incdir+include
logic/cdc_pkg.sv
logic/merge_pkg.sv
logic/fifo_ram.sv
logic/ptr_handshake_sync.sv
logic/cdc_fifo.sv
logic/channel_merger.sv
logic/dual_channel_collector.sv
test/tb_collector.sv

//--- logic/cdc_fifo.sv
module cdc_fifo #(
	parameter int data_width = 16,
	parameter int depth = 16
) (
	input wire wr_clk,
	input wire wr_reset,
	input wire wr_valid,
	input wire [data_width-1:0] wr_data,
	output logic wr_ready,

	input wire rd_clk,
	input wire rd_reset,
	input wire rd_en,
	output logic [data_width-1:0] rd_data,
	output logic rd_empty,
	output logic [cdc_pkg::ptr_bits-1:0] rd_level
);

	// Pointer carries one wrap bit above the address
	localparam int ptr_w = cdc_pkg::ptr_bits;
	localparam int addr_w = ptr_w - 1;

	// Depth in pointer arithmetic width
	localparam logic [ptr_w-1:0] depth_count = ptr_w'(depth);

	// Write domain
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] wr_rd_ptr;
	logic [ptr_w-1:0] wr_used;
	logic wr_take;
	logic wr_sync_busy;
	logic wr_publish;
	logic wr_ptr_ack;

	// Read domain
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] rd_wr_ptr;
	logic rd_take;
	logic rd_sync_busy;
	logic rd_publish;
	logic rd_ptr_ack;

	//////////////////////////////////////////////////
	// Storage

	fifo_ram #(
		.data_width(data_width),
		.depth(depth)
	) u_ram (
		.wr_clk(wr_clk),
		.wr_en(wr_take),
		.wr_addr(wr_ptr[addr_w-1:0]),
		.wr_data(wr_data),
		.rd_clk(rd_clk),
		.rd_en(rd_take),
		.rd_addr(rd_ptr[addr_w-1:0]),
		.rd_data(rd_data)
	);

	//////////////////////////////////////////////////
	// Pointer crossing

	// Write pointer into the read domain
	// Update pulse not needed since the value holds between updates
	ptr_handshake_sync #(
		.width(ptr_w)
	) u_wr_ptr_sync (
		.src_clk(wr_clk),
		.src_reset(wr_reset),
		.src_load(wr_publish),
		.src_value(wr_ptr),
		.src_ack(wr_ptr_ack),
		.dst_clk(rd_clk),
		.dst_reset(rd_reset),
		.dst_updated(),
		.dst_value(rd_wr_ptr)
	);

	// Read pointer into the write domain
	ptr_handshake_sync #(
		.width(ptr_w)
	) u_rd_ptr_sync (
		.src_clk(rd_clk),
		.src_reset(rd_reset),
		.src_load(rd_publish),
		.src_value(rd_ptr),
		.src_ack(rd_ptr_ack),
		.dst_clk(wr_clk),
		.dst_reset(wr_reset),
		.dst_updated(),
		.dst_value(wr_rd_ptr)
	);

	//////////////////////////////////////////////////
	// Write side

	// Stale read pointer only makes full pessimistic
	assign wr_used = wr_ptr - wr_rd_ptr;
	assign wr_ready = (wr_used != depth_count);
	assign wr_take = wr_valid && wr_ready;

	// Republish as soon as the previous transfer completes
	assign wr_publish = !wr_sync_busy || wr_ptr_ack;

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			wr_ptr <= '0;
			wr_sync_busy <= 1'b0;
		end else begin
			if (wr_take) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// One transfer always in flight after the first load
			wr_sync_busy <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Read side

	// Stale write pointer only makes empty pessimistic
	assign rd_empty = (rd_wr_ptr == rd_ptr);
	assign rd_level = rd_wr_ptr - rd_ptr;
	assign rd_take = rd_en && !rd_empty;

	assign rd_publish = !rd_sync_busy || rd_ptr_ack;

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			rd_ptr <= '0;
			rd_sync_busy <= 1'b0;
		end else begin
			if (rd_take) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			rd_sync_busy <= 1'b1;
		end
	end

endmodule

//--- logic/cdc_pkg.sv
package cdc_pkg;

	//////////////////////////////////////////////////
	// FIFO geometry

	// Width of one captured word
	localparam int DATA_WIDTH = 16;

	// Address bits of one FIFO RAM
	// Depth derives from this so it stays a power of two
	localparam int addr_bits = 4;

	// Entries per FIFO
	localparam int FIFO_DEPTH = 1 << addr_bits;

	//////////////////////////////////////////////////
	// Pointer width

	// Address plus one wrap bit
	// Wrap bit tells full from empty when addresses match
	// Also wide enough to hold a level of FIFO_DEPTH
	localparam int ptr_bits = addr_bits + 1;

endpackage

//--- logic/channel_merger.sv
module channel_merger #(
	parameter int data_width = 16
) (
	input wire rd_clk,
	input wire rd_reset,

	input wire a_empty,
	input wire [data_width-1:0] a_data,
	output logic a_rd_en,

	input wire b_empty,
	input wire [data_width-1:0] b_data,
	output logic b_rd_en,

	input wire out_ready,
	output logic out_valid,
	output logic [data_width-1:0] out_data,
	output merge_pkg::channel_t out_channel
);

	// FSM state
	merge_pkg::merge_state_t state;

	// Channel served first on the next pick
	merge_pkg::channel_t pref;

	// Channel picked in idle
	merge_pkg::channel_t sel;

	// Next pick, valid when any channel has data
	merge_pkg::channel_t pick;
	logic any_ready;

	//////////////////////////////////////////////////
	// Round robin pick

	assign any_ready = !a_empty || !b_empty;

	always_comb begin
		if (pref == merge_pkg::CH_A) begin
			// A first, fall back to B
			pick = a_empty ? merge_pkg::CH_B : merge_pkg::CH_A;
		end else begin
			// B first, fall back to A
			pick = b_empty ? merge_pkg::CH_A : merge_pkg::CH_B;
		end
	end

	//////////////////////////////////////////////////
	// FSM

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			state <= merge_pkg::MS_IDLE;
			pref <= merge_pkg::CH_A;
			sel <= merge_pkg::CH_A;
		end else begin
			case (state)
				merge_pkg::MS_IDLE: begin
					if (any_ready) begin
						sel <= pick;
						state <= merge_pkg::MS_FETCH;
					end
				end
				merge_pkg::MS_FETCH: begin
					// RAM output register loads on this edge
					state <= merge_pkg::MS_HOLD;
				end
				merge_pkg::MS_HOLD: begin
					if (out_ready) begin
						state <= merge_pkg::MS_IDLE;
						// Hand priority to the other channel
						if (sel == merge_pkg::CH_A) begin
							pref <= merge_pkg::CH_B;
						end else begin
							pref <= merge_pkg::CH_A;
						end
					end
				end
				default: begin
					state <= merge_pkg::MS_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Read strobes and output

	// One read per word, only to the picked channel
	// Picked FIFO was non-empty and nothing else drains it
	assign a_rd_en = (state == merge_pkg::MS_FETCH) && (sel == merge_pkg::CH_A);
	assign b_rd_en = (state == merge_pkg::MS_FETCH) && (sel == merge_pkg::CH_B);

	// RAM output registers hold the word through MS_HOLD
	// No further read happens until acceptance
	assign out_valid = (state == merge_pkg::MS_HOLD);
	assign out_data = (sel == merge_pkg::CH_A) ? a_data : b_data;
	assign out_channel = sel;

endmodule

//--- logic/dual_channel_collector.sv
module dual_channel_collector #(
	parameter int data_width = cdc_pkg::DATA_WIDTH,
	parameter int depth = cdc_pkg::FIFO_DEPTH
) (
	input wire rd_clk,
	input wire rd_reset,
	input wire wr_clk_a,
	input wire wr_reset_a,
	input wire wr_clk_b,
	input wire wr_reset_b,

	input wire a_valid,
	input wire [data_width-1:0] a_data,
	output logic a_ready,

	input wire b_valid,
	input wire [data_width-1:0] b_data,
	output logic b_ready,

	input wire out_ready,
	output logic out_valid,
	output logic [data_width-1:0] out_data,
	output merge_pkg::channel_t out_channel,

	output logic [cdc_pkg::ptr_bits-1:0] a_level,
	output logic [cdc_pkg::ptr_bits-1:0] b_level
);

	// FIFO read ports in the rd_clk domain
	logic a_empty;
	logic a_rd_en;
	logic [data_width-1:0] a_rd_data;
	logic b_empty;
	logic b_rd_en;
	logic [data_width-1:0] b_rd_data;

	//////////////////////////////////////////////////
	// Channel FIFOs

	// Channel A crosses from wr_clk_a
	cdc_fifo #(
		.data_width(data_width),
		.depth(depth)
	) u_fifo_a (
		.wr_clk(wr_clk_a),
		.wr_reset(wr_reset_a),
		.wr_valid(a_valid),
		.wr_data(a_data),
		.wr_ready(a_ready),
		.rd_clk(rd_clk),
		.rd_reset(rd_reset),
		.rd_en(a_rd_en),
		.rd_data(a_rd_data),
		.rd_empty(a_empty),
		.rd_level(a_level)
	);

	// Channel B crosses from wr_clk_b
	cdc_fifo #(
		.data_width(data_width),
		.depth(depth)
	) u_fifo_b (
		.wr_clk(wr_clk_b),
		.wr_reset(wr_reset_b),
		.wr_valid(b_valid),
		.wr_data(b_data),
		.wr_ready(b_ready),
		.rd_clk(rd_clk),
		.rd_reset(rd_reset),
		.rd_en(b_rd_en),
		.rd_data(b_rd_data),
		.rd_empty(b_empty),
		.rd_level(b_level)
	);

	//////////////////////////////////////////////////
	// Merge into one tagged stream

	channel_merger #(
		.data_width(data_width)
	) u_merger (
		.rd_clk(rd_clk),
		.rd_reset(rd_reset),
		.a_empty(a_empty),
		.a_data(a_rd_data),
		.a_rd_en(a_rd_en),
		.b_empty(b_empty),
		.b_data(b_rd_data),
		.b_rd_en(b_rd_en),
		.out_ready(out_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_channel(out_channel)
	);

endmodule

//--- logic/fifo_ram.sv
module fifo_ram #(
	parameter int data_width = 16,
	parameter int depth = 16
) (
	input wire wr_clk,
	input wire wr_en,
	input wire [$clog2(depth)-1:0] wr_addr,
	input wire [data_width-1:0] wr_data,

	input wire rd_clk,
	input wire rd_en,
	input wire [$clog2(depth)-1:0] rd_addr,
	output logic [data_width-1:0] rd_data
);

	// Storage array
	// Plain flops or distributed RAM after synthesis
	logic [data_width-1:0] mem [depth];

	//////////////////////////////////////////////////
	// Write port

	// One word per wr_clk edge
	always_ff @(posedge wr_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	//////////////////////////////////////////////////
	// Read port

	// Registered output on the read clock
	// Word shows up the cycle after rd_en
	// Output keeps its value while rd_en is low
	always_ff @(posedge rd_clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

//--- logic/merge_pkg.sv
package merge_pkg;

	//////////////////////////////////////////////////
	// Channel tag

	// Source of an output word
	// One bit since there are only two producers
	typedef enum logic {
		CH_A = 1'b0,
		CH_B = 1'b1
	} channel_t;

	//////////////////////////////////////////////////
	// Merger FSM

	// Idle picks a channel
	// Fetch issues one RAM read
	// Hold presents the word until accepted
	typedef enum logic [1:0] {
		MS_IDLE  = 2'd0,
		MS_FETCH = 2'd1,
		MS_HOLD  = 2'd2
	} merge_state_t;

endpackage

//--- logic/ptr_handshake_sync.sv
module ptr_handshake_sync #(
	parameter int width = 5
) (
	input wire src_clk,
	input wire src_reset,
	input wire src_load,
	input wire [width-1:0] src_value,
	output logic src_ack,

	input wire dst_clk,
	input wire dst_reset,
	output logic dst_updated,
	output logic [width-1:0] dst_value
);

	// Source domain state
	logic [width-1:0] src_hold;
	logic src_req;
	logic [1:0] src_ack_sync;
	logic src_ack_last;

	// Destination domain state
	logic [1:0] dst_req_sync;
	logic dst_req_last;
	logic dst_ack;
	logic dst_edge;

	//////////////////////////////////////////////////
	// Source side

	// Holding register stays put until the ack comes back
	always_ff @(posedge src_clk) begin
		if (src_load) begin
			src_hold <= src_value;
		end
	end

	// Request toggle and returning ack synchronizer
	always_ff @(posedge src_clk) begin
		if (src_reset) begin
			src_req <= 1'b0;
			src_ack_sync <= 2'b00;
			src_ack_last <= 1'b0;
		end else begin
			if (src_load) begin
				src_req <= ~src_req;
			end
			src_ack_sync <= {src_ack_sync[0], dst_ack};
			src_ack_last <= src_ack_sync[1];
		end
	end

	// Ack toggle changed, one cycle pulse
	assign src_ack = src_ack_sync[1] ^ src_ack_last;

	//////////////////////////////////////////////////
	// Destination side

	// New request when the synced toggle changes
	assign dst_edge = dst_req_sync[1] ^ dst_req_last;

	always_ff @(posedge dst_clk) begin
		if (dst_reset) begin
			dst_req_sync <= 2'b00;
			dst_req_last <= 1'b0;
			dst_ack <= 1'b0;
			dst_updated <= 1'b0;
			dst_value <= '0;
		end else begin
			// Two flops against metastability
			dst_req_sync <= {dst_req_sync[0], src_req};
			dst_req_last <= dst_req_sync[1];
			dst_updated <= dst_edge;
			if (dst_edge) begin
				// src_hold is stable here, safe to sample
				dst_value <= src_hold;
				// Echo the toggle back as the ack
				dst_ack <= dst_req_sync[1];
			end
		end
	end

endmodule

//--- include/tb_util.svh
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

//////////////////////////////////////////////////
// Random source

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr_state = 32'd83470;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit taken, LSB out first
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		r = {r[30:0], lfsr_state[0]};
		lfsr_state = lfsr_next(lfsr_state);
	end
	return r;
endfunction

//////////////////////////////////////////////////
// Error tracking

int value_errors = 0;
int other_errors = 0;

task automatic check_value(input string name, input logic [31:0] got,
	input logic [31:0] expected);
	if (got !== expected) begin
		value_errors++;
		$display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
	end
endtask

// Anything that is not a plain value mismatch
task automatic report_problem(input string msg);
	other_errors++;
	$display("Error: %s at %0t", msg, $time);
endtask

`endif

//--- test/tb_collector.sv
module tb_collector;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int data_width = cdc_pkg::DATA_WIDTH;
	localparam int depth = cdc_pkg::FIFO_DEPTH;

	// Words over all tests, fill test counts its drain twice
	localparam int word_total = 10 + 2 * (depth + 1) + 10 + 2 * 60;
	// Slowest word with gated valid and ready, plus settle waits
	localparam int per_word_ns = 600;
	localparam int watchdog_ns = word_total * per_word_ns + 20000;

	logic rd_clk = 1'b0;
	logic wr_clk_a = 1'b0;
	logic wr_clk_b = 1'b0;
	logic rd_reset = 1'b1;
	logic wr_reset_a = 1'b1;
	logic wr_reset_b = 1'b1;

	// Index 0 is channel A, index 1 is channel B
	logic [1:0] wr_valid = 2'b00;
	logic [data_width-1:0] wr_word [2] = '{'0, '0};
	wire [1:0] wr_ready;

	logic out_ready = 1'b0;
	logic out_valid;
	logic [data_width-1:0] out_data;
	merge_pkg::channel_t out_channel;
	logic [cdc_pkg::ptr_bits-1:0] a_level;
	logic [cdc_pkg::ptr_bits-1:0] b_level;

	// Accepted words not yet seen at the output
	logic [data_width-1:0] model_a[$];
	logic [data_width-1:0] model_b[$];

	`include "tb_util.svh"

	always #10 rd_clk = ~rd_clk;
	always #7 wr_clk_a = ~wr_clk_a;
	always #17 wr_clk_b = ~wr_clk_b;

	dual_channel_collector #(
		.data_width(data_width),
		.depth(depth)
	) u_dual_channel_collector (
		.rd_clk(rd_clk),
		.rd_reset(rd_reset),
		.wr_clk_a(wr_clk_a),
		.wr_reset_a(wr_reset_a),
		.wr_clk_b(wr_clk_b),
		.wr_reset_b(wr_reset_b),
		.a_valid(wr_valid[0]),
		.a_data(wr_word[0]),
		.a_ready(wr_ready[0]),
		.b_valid(wr_valid[1]),
		.b_data(wr_word[1]),
		.b_ready(wr_ready[1]),
		.out_ready(out_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_channel(out_channel),
		.a_level(a_level),
		.b_level(b_level)
	);

	//////////////////////////////////////////////////
	// Producer side

	task automatic wait_wr_edge(input int ch);
		if (ch == 0) begin
			@(posedge wr_clk_a);
		end else begin
			@(posedge wr_clk_b);
		end
	endtask

	task automatic record_word(input int ch, input logic [data_width-1:0] word);
		if (ch == 0) begin
			model_a.push_back(word);
		end else begin
			model_b.push_back(word);
		end
	endtask

	// Offer count words, stop early once ready stays low for stall_limit edges
	task automatic write_words(input int ch, input int count, input bit gated,
		input int stall_limit, output int sent);
		int stall;
		logic go;
		sent = 0;
		stall = 0;
		while (sent < count && (stall_limit == 0 || stall < stall_limit)) begin
			wait_wr_edge(ch);
			// Pre-edge valid and ready, same as the FIFO sees them
			if (wr_valid[ch] && wr_ready[ch]) begin
				record_word(ch, wr_word[ch]);
				sent++;
			end
			stall = wr_ready[ch] ? 0 : stall + 1;
			// An offered word holds until taken
			if (!wr_valid[ch] || wr_ready[ch]) begin
				go = (sent < count) && (!gated || rand_bits(1) != 0);
				wr_valid[ch] <= go;
				if (go) begin
					wr_word[ch] <= data_width'(rand_bits(data_width));
				end
			end
		end
		wr_valid[ch] <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Consumer side

	task automatic match_word(input merge_pkg::channel_t ch,
		input logic [data_width-1:0] word);
		logic [data_width-1:0] expected;
		if (ch == merge_pkg::CH_A && model_a.size() > 0) begin
			expected = model_a.pop_front();
			check_value("out_data", word, expected);
		end else if (ch == merge_pkg::CH_B && model_b.size() > 0) begin
			expected = model_b.pop_front();
			check_value("out_data", word, expected);
		end else begin
			report_problem($sformatf("word 0x%0h tagged %s arrived with none pending",
				word, ch.name()));
		end
	endtask

	// Take count words, optionally with random ready and a tag alternation check
	task automatic read_words(input int count, input bit gated, input bit alternate);
		int got;
		logic held;
		logic [data_width-1:0] held_data;
		merge_pkg::channel_t held_ch;
		merge_pkg::channel_t last_ch;
		got = 0;
		held = 1'b0;
		held_data = '0;
		held_ch = merge_pkg::CH_A;
		last_ch = merge_pkg::CH_A;
		while (got < count) begin
			@(posedge rd_clk);
			// Stalled word must stay put
			if (held) begin
				check_value("out_valid", out_valid, 1'b1);
				check_value("out_data", out_data, held_data);
				check_value("out_channel", out_channel, held_ch);
			end
			held = out_valid && !out_ready;
			held_data = out_data;
			held_ch = out_channel;
			if (out_valid && out_ready) begin
				if (alternate && got > 0 && out_channel == last_ch) begin
					report_problem("two words in a row from the same channel");
				end
				last_ch = out_channel;
				match_word(out_channel, out_data);
				got++;
			end
			out_ready <= (got < count) && (!gated || rand_bits(1) != 0);
		end
	endtask

	// Nothing extra at the output, all written words seen, FIFOs empty again
	task automatic expect_drained(input string test_name);
		repeat (40) @(posedge rd_clk);
		check_value("out_valid", out_valid, 1'b0);
		check_value("a_level", a_level, 0);
		check_value("b_level", b_level, 0);
		@(posedge wr_clk_a);
		check_value("a_ready", wr_ready[0], 1'b1);
		@(posedge wr_clk_b);
		check_value("b_ready", wr_ready[1], 1'b1);
		if (model_a.size() != 0 || model_b.size() != 0) begin
			report_problem($sformatf("%s: %0d words on A and %0d on B never arrived",
				test_name, model_a.size(), model_b.size()));
		end
		model_a.delete();
		model_b.delete();
	endtask

	//////////////////////////////////////////////////
	// Directed tests

	task automatic apply_reset();
		repeat (8) @(posedge rd_clk);
		rd_reset <= 1'b0;
		@(posedge wr_clk_a);
		wr_reset_a <= 1'b0;
		@(posedge wr_clk_b);
		wr_reset_b <= 1'b0;
	endtask

	task automatic test_reset_state();
		@(posedge rd_clk);
		check_value("out_valid", out_valid, 1'b0);
		check_value("a_level", a_level, 0);
		check_value("b_level", b_level, 0);
		@(posedge wr_clk_a);
		check_value("a_ready", wr_ready[0], 1'b1);
		@(posedge wr_clk_b);
		check_value("b_ready", wr_ready[1], 1'b1);
	endtask

	task automatic test_single_channel();
		int sent;
		fork
			write_words(0, 10, 1'b0, 0, sent);
			read_words(10, 1'b0, 1'b0);
		join
		expect_drained("single channel");
	endtask

	task automatic test_backpressure();
		int sent;
		// FIFO fills to depth, one more word waits in the merger hold stage
		write_words(1, 4 * depth, 1'b0, 40, sent);
		check_value("b accepted words", sent, depth + 1);
		repeat (40) @(posedge rd_clk);
		check_value("b_level", b_level, depth);
		read_words(depth + 1, 1'b1, 1'b0);
		expect_drained("back-pressure");
	endtask

	task automatic test_fairness();
		int sent_a;
		int sent_b;
		fork
			write_words(0, 5, 1'b0, 0, sent_a);
			write_words(1, 5, 1'b0, 0, sent_b);
		join
		// One of the ten sits in the merger already
		do begin
			@(posedge rd_clk);
		end while (a_level + b_level != 9);
		read_words(10, 1'b0, 1'b1);
		expect_drained("fairness");
	endtask

	task automatic test_random();
		int sent_a;
		int sent_b;
		fork
			write_words(0, 60, 1'b1, 0, sent_a);
			write_words(1, 60, 1'b1, 0, sent_b);
			read_words(120, 1'b1, 1'b0);
		join
		expect_drained("random traffic");
	endtask

	//////////////////////////////////////////////////
	// Run control

	initial begin
		apply_reset();
		test_reset_state();
		test_single_channel();
		test_backpressure();
		test_fairness();
		test_random();
		$display("Errors: %0d value mismatches, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// Hung handshake or lost word
	initial begin
		#(watchdog_ns);
		$display("Error: run still busy after %0d ns, stopped by watchdog", watchdog_ns);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
